// File: include/mac_params.svh
`ifndef MAC_PARAMS_SVH
`define MAC_PARAMS_SVH

// ********************************************************************
// word widths
// ********************************************************************

// pixel and weight are signed bytes
`define MAC_WIDTH_IN    8
// partial sums and the accumulator wrap at this width
`define MAC_WIDTH_OUT   24

// ********************************************************************
// pipeline latencies, counted in enabled cycles
// ********************************************************************

// accepted beat to product
`define MAC_LATENCY_MUL 2
// product to updated accumulator
`define MAC_LATENCY_ACC 2

// number of nonzero terms reported with a sum
`define MAC_TERM_WIDTH  8

`endif

// File: logic/accumulator.sv
`default_nettype none

`include "mac_params.svh"

module accumulator
  import mac_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        en,
  input  prod_beat_t  prod,
  input  logic        prod_valid,
  output mac_result_t result,
  output logic        result_valid
);

  localparam int W_IN   = `MAC_WIDTH_IN;
  localparam int W_OUT  = `MAC_WIDTH_OUT;
  localparam int TERM_W = `MAC_TERM_WIDTH;
  localparam int OP_W   = $bits(mac_op_t);
  localparam int PRE_W  = W_OUT + OP_W + 2;

  logic signed [W_OUT-1:0]  addend;
  logic [PRE_W-1:0]         pre_in;
  logic [PRE_W-1:0]         pre_out;
  logic signed [W_OUT-1:0]  addend_d;
  mac_op_t                  op_d;
  logic                     nonzero_d;
  logic                     last_d;
  logic                     valid_d;
  logic signed [W_OUT-1:0]  acc_q;
  logic signed [W_OUT-1:0]  feedback;
  logic signed [W_OUT-1:0]  acc_next;
  logic [TERM_W-1:0]        terms_q;
  logic [TERM_W-1:0]        terms_next;
  logic                     step;
  logic                     result_valid_q;

  // ********************************************************************
  // addend select and pre-add stage
  // ********************************************************************

  // a skipped product counts as zero whatever the multiplier shows
  always_comb begin
    case (prod.op)
      OP_PSUM: addend = prod.psum;
      default: begin
        if (prod.nonzero) begin
          addend = {{(W_OUT - 2*W_IN){prod.product[2*W_IN-1]}}, prod.product};
        end else begin
          addend = '0;
        end
      end
    endcase
  end

  assign pre_in = {addend, prod.op, prod.nonzero, prod.last};

  delay_line #(
    .DEPTH (`MAC_LATENCY_ACC - 1),
    .WIDTH (PRE_W)
  ) u_pre_dly (
    .clk   (clk),
    .rst_n (rst_n),
    .en    (en),
    .d     (pre_in),
    .q     (pre_out)
  );

  delay_line #(
    .DEPTH (`MAC_LATENCY_ACC - 1),
    .WIDTH (1)
  ) u_valid_dly (
    .clk   (clk),
    .rst_n (rst_n),
    .en    (en),
    .d     (prod_valid),
    .q     (valid_d)
  );

  always_comb begin
    addend_d  = pre_out[PRE_W-1 -: W_OUT];
    op_d      = mac_op_t'(pre_out[OP_W+1:2]);
    nonzero_d = pre_out[1];
    last_d    = pre_out[0];
  end

  // ********************************************************************
  // accumulate and count terms
  // ********************************************************************

  assign step = en && valid_d;

  // a load starts a new sum, so the old value is not fed back
  assign feedback = (op_d == OP_LOAD) ? '0 : acc_q;
  assign acc_next = feedback + addend_d;

  always_comb begin
    case (op_d)
      OP_LOAD: terms_next = TERM_W'(nonzero_d);
      OP_MAC:  terms_next = terms_q + TERM_W'(nonzero_d);
      default: terms_next = terms_q;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      acc_q          <= '0;
      terms_q        <= '0;
      result_valid_q <= 1'b0;
    end else if (en) begin
      result_valid_q <= valid_d && last_d;
      if (valid_d) begin
        acc_q   <= acc_next;
        terms_q <= terms_next;
      end
    end
  end

  // ********************************************************************
  // result
  // ********************************************************************

  always_ff @(posedge clk) begin
    if (step && last_d) begin
      result.sum   <= acc_next;
      result.terms <= terms_next;
    end
  end

  // the strobe holds through a stall and only shows while enabled
  assign result_valid = result_valid_q && en;

endmodule

`default_nettype wire

// File: logic/delay_line.sv
`default_nettype none

module delay_line #(
  parameter int DEPTH = 2,
  parameter int WIDTH = 8
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             en,
  input  logic [WIDTH-1:0] d,
  output logic [WIDTH-1:0] q
);

  // ********************************************************************
  // register chain
  // ********************************************************************

  // stage 0 takes the input, the last stage drives q
  logic [WIDTH-1:0] stage [DEPTH];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        stage[i] <= '0;
      end
    end else if (en) begin
      stage[0] <= d;
      // with a single stage this loop has no iterations
      for (int i = 1; i < DEPTH; i++) begin
        stage[i] <= stage[i-1];
      end
    end
  end

  assign q = stage[DEPTH-1];

endmodule

`default_nettype wire

// File: logic/mac_engine.sv
`default_nettype none

module mac_engine
  import mac_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        en,
  input  mac_beat_t   in_beat,
  input  logic        in_valid,
  output mac_result_t result,
  output logic        result_valid
);

  // ********************************************************************
  // product path between the two stages
  // ********************************************************************

  prod_beat_t prod;
  logic       prod_valid;

  // multiply with zero skipping, control fields ride along
  mul_stage u_mul_stage (
    .clk        (clk),
    .rst_n      (rst_n),
    .en         (en),
    .in_beat    (in_beat),
    .in_valid   (in_valid),
    .prod       (prod),
    .prod_valid (prod_valid)
  );

  // addend select, running sum and result strobe
  accumulator u_accumulator (
    .clk          (clk),
    .rst_n        (rst_n),
    .en           (en),
    .prod         (prod),
    .prod_valid   (prod_valid),
    .result       (result),
    .result_valid (result_valid)
  );

endmodule

`default_nettype wire

// File: logic/mac_pkg.sv
`default_nettype none

`include "mac_params.svh"

package mac_pkg;

  // accumulator operation carried with every beat
  typedef enum logic [1:0] {
    OP_LOAD = 2'd0,
    OP_MAC  = 2'd1,
    OP_PSUM = 2'd2
  } mac_op_t;

  // idle after reset or after a result, running inside a segment
  typedef enum logic {
    ACC_IDLE = 1'b0,
    ACC_RUN  = 1'b1
  } acc_state_t;

  typedef struct packed {
    logic signed [`MAC_WIDTH_IN-1:0]  pixel;
    logic signed [`MAC_WIDTH_IN-1:0]  weight;
    logic signed [`MAC_WIDTH_OUT-1:0] psum;
    mac_op_t                          op;
    logic                             last;
  } mac_beat_t;

  // product is only meaningful when nonzero is set
  typedef struct packed {
    logic signed [2*`MAC_WIDTH_IN-1:0] product;
    logic                              nonzero;
    logic signed [`MAC_WIDTH_OUT-1:0]  psum;
    mac_op_t                           op;
    logic                              last;
  } prod_beat_t;

  typedef struct packed {
    logic signed [`MAC_WIDTH_OUT-1:0] sum;
    logic [`MAC_TERM_WIDTH-1:0]       terms;
  } mac_result_t;

endpackage

`default_nettype wire

// File: logic/mul_stage.sv
`default_nettype none

`include "mac_params.svh"

module mul_stage
  import mac_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       en,
  input  mac_beat_t  in_beat,
  input  logic       in_valid,
  output prod_beat_t prod,
  output logic       prod_valid
);

  localparam int W_IN   = `MAC_WIDTH_IN;
  localparam int W_OUT  = `MAC_WIDTH_OUT;
  localparam int OPND_W = 2 * W_IN;
  localparam int OP_W   = $bits(mac_op_t);
  localparam int CTRL_W = 1 + W_OUT + OP_W + 1;

  logic                    operands_nonzero;
  logic                    capture_en;
  logic signed [W_IN-1:0]  pixel_q;
  logic signed [W_IN-1:0]  weight_q;
  logic signed [W_IN-1:0]  pixel_d;
  logic signed [W_IN-1:0]  weight_d;
  logic [CTRL_W-1:0]       ctrl_in;
  logic [CTRL_W-1:0]       ctrl_out;

  // ********************************************************************
  // zero skip and operand capture
  // ********************************************************************

  assign operands_nonzero = (|in_beat.pixel) && (|in_beat.weight);

  // a zero operand leaves the capture registers untouched, so the
  // multiplier inputs do not toggle for that beat
  assign capture_en = en && in_valid && operands_nonzero;

  always_ff @(posedge clk) begin
    if (capture_en) begin
      pixel_q  <= in_beat.pixel;
      weight_q <= in_beat.weight;
    end
  end

  // remaining operand stages shift on every enabled cycle to stay in
  // step with the control pipeline
  delay_line #(
    .DEPTH (`MAC_LATENCY_MUL - 1),
    .WIDTH (OPND_W)
  ) u_opnd_dly (
    .clk   (clk),
    .rst_n (rst_n),
    .en    (en),
    .d     ({pixel_q, weight_q}),
    .q     ({pixel_d, weight_d})
  );

  // ********************************************************************
  // control and valid pipelines
  // ********************************************************************

  assign ctrl_in = {operands_nonzero, in_beat.psum, in_beat.op, in_beat.last};

  delay_line #(
    .DEPTH (`MAC_LATENCY_MUL),
    .WIDTH (CTRL_W)
  ) u_ctrl_dly (
    .clk   (clk),
    .rst_n (rst_n),
    .en    (en),
    .d     (ctrl_in),
    .q     (ctrl_out)
  );

  delay_line #(
    .DEPTH (`MAC_LATENCY_MUL),
    .WIDTH (1)
  ) u_valid_dly (
    .clk   (clk),
    .rst_n (rst_n),
    .en    (en),
    .d     (in_valid),
    .q     (prod_valid)
  );

  // ********************************************************************
  // signed product
  // ********************************************************************

  always_comb begin
    prod.product = pixel_d * weight_d;
    prod.nonzero = ctrl_out[CTRL_W-1];
    prod.psum    = ctrl_out[CTRL_W-2 -: W_OUT];
    prod.op      = mac_op_t'(ctrl_out[OP_W:1]);
    prod.last    = ctrl_out[0];
  end

endmodule

`default_nettype wire

// File: mac_engine.f
+incdir+include
logic/mac_pkg.sv
logic/delay_line.sv
logic/mul_stage.sv
logic/accumulator.sv
logic/mac_engine.sv
testbench/tb_mac_engine.sv

// File: testbench/tb_mac_engine.sv
`default_nettype none

`include "mac_params.svh"

module tb_mac_engine
  import mac_pkg::*;
();

  localparam int LATENCY   = `MAC_LATENCY_MUL + `MAC_LATENCY_ACC;
  localparam int SEG_MAX   = 12;
  localparam int N_MIX     = 30;
  localparam int N_ZERO    = 20;
  localparam int N_PSUM    = 20;
  localparam int N_STALL   = 20;
  localparam int N_CONT    = 10;
  localparam int WRAP_LEN  = 520;
  localparam int MAX_STALL = 5;
  localparam int STIM_CYCLES = 8 + 20 + SEG_MAX * (N_MIX + N_ZERO + N_PSUM + N_CONT)
                               + WRAP_LEN + SEG_MAX * N_STALL * (1 + MAX_STALL) + 8 * 10;
  localparam int CYCLE_LIMIT = 4 * STIM_CYCLES + 200;

  logic        clk;
  logic        rst_n;
  logic        en;
  mac_beat_t   in_beat;
  logic        in_valid;
  mac_result_t result;
  logic        result_valid;

  integer      seed;
  int unsigned cycles;
  int unsigned en_ticks;
  int unsigned accept_tick;
  mac_beat_t   seg_q[$];
  mac_result_t exp_q[$];
  int unsigned tick_q[$];
  mac_result_t model;
  mac_result_t expected;

  mac_engine mac_engine_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .en           (en),
    .in_beat      (in_beat),
    .in_valid     (in_valid),
    .result       (result),
    .result_valid (result_valid)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ********************************************************************
  // reference model and helpers
  // ********************************************************************

  // one beat of the accumulation rule applied to the running sum and terms
  function automatic mac_result_t ref_step(input mac_result_t acc, input mac_beat_t b);
    logic signed [`MAC_WIDTH_IN-1:0]    px;
    logic signed [`MAC_WIDTH_IN-1:0]    wt;
    logic signed [2*`MAC_WIDTH_IN-1:0]  p;
    logic signed [`MAC_WIDTH_OUT-1:0]   term;
    logic                               nz;
    mac_result_t                        r;
    px   = b.pixel;
    wt   = b.weight;
    nz   = (px != 0) && (wt != 0);
    p    = px * wt;
    if (nz) begin
      term = p;
    end else begin
      term = '0;
    end
    r    = acc;
    case (b.op)
      OP_LOAD: begin
        r.sum   = term;
        r.terms = {{(`MAC_TERM_WIDTH-1){1'b0}}, nz};
      end
      OP_MAC: begin
        r.sum   = acc.sum + term;
        r.terms = acc.terms + {{(`MAC_TERM_WIDTH-1){1'b0}}, nz};
      end
      default: r.sum = acc.sum + b.psum;
    endcase
    return r;
  endfunction

  function automatic int pick(input int n);
    int unsigned r;
    r = $random(seed);
    return r % n;
  endfunction

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Testbench failed");
    $fatal(1);
  endtask

  // fills seg_q with one segment that ends in a last beat
  task automatic gen_segment(input int len, input bit open_load, input int zero_pct,
                             input int psum_pct);
    mac_beat_t b;
    for (int i = 0; i < len; i++) begin
      b.pixel  = pick(256);
      b.weight = pick(256);
      b.psum   = $random(seed);
      if (pick(100) < zero_pct) begin
        if (pick(2) != 0) begin
          b.pixel = '0;
        end else begin
          b.weight = '0;
        end
      end else begin
        if (b.pixel == 0) b.pixel = 1;
        if (b.weight == 0) b.weight = 1;
      end
      if (i == 0 && open_load) begin
        b.op = OP_LOAD;
      end else if (pick(100) < psum_pct) begin
        b.op = OP_PSUM;
      end else begin
        b.op = OP_MAC;
      end
      b.last = (i == len - 1);
      seg_q.push_back(b);
    end
  endtask

  task automatic drive_beat(input mac_beat_t b);
    @(posedge clk);
    en       <= 1'b1;
    in_beat  <= b;
    in_valid <= 1'b1;
  endtask

  // a frozen cycle carrying a junk strobe that the DUT must ignore
  task automatic stall_cycle();
    logic [63:0] junk;
    junk = {$random(seed), $random(seed)};
    @(posedge clk);
    en       <= 1'b0;
    in_beat  <= junk[$bits(mac_beat_t)-1:0];
    in_valid <= 1'b1;
  endtask

  task automatic send_segment(input int stall_pct);
    int n;
    while (seg_q.size() != 0) begin
      drive_beat(seg_q.pop_front());
      if (pick(100) < stall_pct) begin
        n = 1 + pick(MAX_STALL);
        repeat (n) stall_cycle();
      end
    end
  endtask

  task automatic drain();
    @(posedge clk);
    en       <= 1'b1;
    in_valid <= 1'b0;
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
  endtask

  // ********************************************************************
  // stimulus
  // ********************************************************************

  initial begin
    seed     = 32'h90e3a253;
    rst_n    = 1'b0;
    en       = 1'b1;
    in_valid = 1'b0;
    in_beat  = '0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    // quiet period, then a single loaded product
    repeat (10) @(posedge clk);
    gen_segment(1, 1'b1, 0, 0);
    send_segment(0);
    drain();
    for (int s = 0; s < N_MIX; s++) begin
      gen_segment(1 + pick(SEG_MAX), 1'b1, 5, 0);
      send_segment(0);
    end
    drain();
    // 520 products of 16384 pass the top of the 24-bit range
    for (int i = 0; i < WRAP_LEN; i++) begin
      seg_q.push_back('{pixel: -8'sd128, weight: -8'sd128, psum: '0,
                        op: (i == 0) ? OP_LOAD : OP_MAC, last: (i == WRAP_LEN - 1)});
    end
    send_segment(0);
    drain();
    for (int s = 0; s < N_ZERO; s++) begin
      gen_segment(1 + pick(SEG_MAX), 1'b1, 50, 0);
      send_segment(0);
    end
    drain();
    for (int s = 0; s < N_PSUM; s++) begin
      gen_segment(1 + pick(SEG_MAX), 1'b1, 20, 40);
      send_segment(0);
    end
    drain();
    for (int s = 0; s < N_STALL; s++) begin
      gen_segment(1 + pick(SEG_MAX), 1'b1, 20, 20);
      send_segment(30);
    end
    drain();
    // segments with no load build on the previous result
    for (int s = 0; s < N_CONT; s++) begin
      gen_segment(1 + pick(SEG_MAX), 1'b0, 20, 20);
      send_segment(0);
    end
    drain();
    repeat (10) @(posedge clk);
    if (exp_q.size() == 0) begin
      $display("Testbench passed");
      $finish;
    end else begin
      report_failure($sformatf("%0d expected results never arrived", exp_q.size()));
    end
  end

  // ********************************************************************
  // comparing process, sampled on the falling edge
  // ********************************************************************

  always @(negedge clk) begin
    if (!rst_n) begin
      model    = '0;
      en_ticks = 0;
    end else begin
      if (!en) begin
        assert (!result_valid) else report_failure("result_valid was high while en was low");
      end
      if (en && in_valid) begin
        model = ref_step(model, in_beat);
        if (in_beat.last) begin
          exp_q.push_back(model);
          tick_q.push_back(en_ticks);
        end
      end
      if (result_valid) begin
        if (exp_q.size() == 0) begin
          report_failure("result_valid arrived with no result expected");
        end
        expected    = exp_q.pop_front();
        accept_tick = tick_q.pop_front();
        assert (result.sum === expected.sum) else
          report_failure($sformatf("Fail at %0t: result.sum expected %0d, got %0d",
                                   $time, expected.sum, result.sum));
        assert (result.terms === expected.terms) else
          report_failure($sformatf("Fail at %0t: result.terms expected %0d, got %0d",
                                   $time, expected.terms, result.terms));
        assert (en_ticks - accept_tick == LATENCY) else
          report_failure($sformatf("Fail at %0t: result_valid latency expected %0d, got %0d",
                                   $time, LATENCY, en_ticks - accept_tick));
      end
      if (en) en_ticks++;
    end
  end

  initial begin
    cycles = 0;
    forever begin
      @(posedge clk);
      cycles++;
      if (cycles >= CYCLE_LIMIT) begin
        report_failure($sformatf("timeout after %0d cycles, results missing", cycles));
      end
    end
  end

endmodule

`default_nettype wire
